/* rename_pkg.sv */
/*
 * rename package
 * register index widths and types, zero register and opcode classes
 * shared by the rename and retire path
 */
`default_nettype none

package rename_pkg;

	//==============================
	// register index widths
	//==============================
	localparam int AREG_W   = 5;   // 32 architectural regs
	localparam int PREG_W   = 6;   // physical tag width
	localparam int NUM_PREG = 64;  // phys regs in the core

	typedef logic [AREG_W-1:0] areg_t;
	typedef logic [PREG_W-1:0] preg_t;

	// r31 reads as zero, never renamed, also "no dest"
	localparam areg_t ZERO_REG = areg_t'(31);

	//==============================
	// instruction classes
	//==============================
	typedef logic [5:0] opcode_t; // inst bits 31:26

	// operate group
	localparam opcode_t OP_INTA = 6'h10; // int arith
	localparam opcode_t OP_INTL = 6'h11; // int logic
	localparam opcode_t OP_INTS = 6'h12; // int shift
	localparam opcode_t OP_INTM = 6'h13; // int mult

	// memory
	localparam opcode_t OP_LDQ  = 6'h29; // quad load, dest in ra
	localparam opcode_t OP_STQ  = 6'h2d; // quad store, no dest

	// branches take up the rest of the space from here up
	localparam opcode_t OP_BR_LO = 6'h30;

endpackage : rename_pkg

`default_nettype wire

/* dispatch_stage.sv */
/*
 * dispatch stage
 * decodes the register fields of an instruction word and gates
 * dispatch on reorder buffer and free list resources
 */
`timescale 1ns/1ns
`default_nettype none

module dispatch_stage (
	input  logic               inst_valid_i,
	input  logic [31:0]        inst_i,
	input  logic               rob_full_i,
	input  logic               fl_empty_i,

	output logic               stall_o,
	output logic               dispatch_en_o,
	output logic               alloc_en_o,
	output rename_pkg::areg_t  src_a_areg_o,
	output rename_pkg::areg_t  src_b_areg_o,
	output rename_pkg::areg_t  dest_areg_o
);
	import rename_pkg::*;

	opcode_t opcode;
	areg_t   ra_field, rb_field, rc_field;
	logic    is_oper, is_load, is_store, is_branch;
	logic    has_dest;

	// instruction word fields
	assign opcode   = inst_i[31:26];
	assign ra_field = inst_i[25:21];
	assign rb_field = inst_i[20:16];
	assign rc_field = inst_i[4:0];

	// opcode classes
	assign is_oper   = opcode inside {OP_INTA, OP_INTL, OP_INTS, OP_INTM};
	assign is_load   = (opcode == OP_LDQ);
	assign is_store  = (opcode == OP_STQ);
	assign is_branch = (opcode >= OP_BR_LO); // top 16 opcodes

	//==============================
	// register selection
	//==============================
	always_comb begin
		src_a_areg_o = ZERO_REG; // unknown classes touch nothing
		src_b_areg_o = ZERO_REG;
		dest_areg_o  = ZERO_REG;
		if (is_oper) begin
			src_a_areg_o = ra_field;
			src_b_areg_o = rb_field;
			dest_areg_o  = rc_field;
		end else if (is_load) begin
			src_b_areg_o = rb_field; // base reg
			dest_areg_o  = ra_field;
		end else if (is_store) begin
			src_a_areg_o = ra_field; // store data
			src_b_areg_o = rb_field; // base reg
		end else if (is_branch) begin
			src_a_areg_o = ra_field; // condition reg
		end
	end

	// writing r31 is the same as writing nothing
	assign has_dest = (dest_areg_o != ZERO_REG);

	//==============================
	// resource gate
	//==============================
	assign stall_o       = rob_full_i | (has_dest & fl_empty_i);
	assign dispatch_en_o = inst_valid_i & ~stall_o;
	assign alloc_en_o    = dispatch_en_o & has_dest; // pop one free preg

endmodule : dispatch_stage

`default_nettype wire

/* map_table.sv */
/*
 * map table
 * speculative architectural to physical register mapping
 * two source reads, old dest read, one dest update per cycle
 */
`timescale 1ns/1ns
`default_nettype none

module map_table (
	input  logic               clk,
	input  logic               reset_i,

	input  logic               dispatch_en_i,
	input  rename_pkg::areg_t  src_a_areg_i,
	input  rename_pkg::areg_t  src_b_areg_i,
	input  rename_pkg::areg_t  dest_areg_i,
	input  rename_pkg::preg_t  new_preg_i,  // free list head

	output rename_pkg::preg_t  src_a_preg_o,
	output rename_pkg::preg_t  src_b_preg_o,
	output rename_pkg::preg_t  old_preg_o   // goes to rob as told
);
	import rename_pkg::*;

	localparam int NUM_AREG = 2 ** AREG_W;

	preg_t map_q [NUM_AREG];

	//==============================
	// lookup
	//==============================
	// reads see the table before this cycle's own update
	assign src_a_preg_o = map_q[src_a_areg_i];
	assign src_b_preg_o = map_q[src_b_areg_i];
	assign old_preg_o   = map_q[dest_areg_i]; // r31 gives 31

	//==============================
	// update
	//==============================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_AREG; i++) begin
				map_q[i] <= preg_t'(i); // identity
			end
		end else if (dispatch_en_i && (dest_areg_i != ZERO_REG)) begin
			map_q[dest_areg_i] <= new_preg_i;
		end
	end

	// zero reg pinned to its own phys reg whatever dispatch sends
	a_zero_pinned: assert property (@(posedge clk) disable iff (reset_i)
		map_q[ZERO_REG] == preg_t'(ZERO_REG))
		else $error("map table entry 31 was renamed");

endmodule : map_table

`default_nettype wire

/* free_list.sv */
/*
 * free list
 * circular queue of unused physical registers
 * pop at head on allocate, push at tail on retire release
 */
`timescale 1ns/1ns
`default_nettype none

module free_list (
	input  logic               clk,
	input  logic               reset_i,

	input  logic               alloc_en_i,     // dispatch with a dest
	input  logic               release_en_i,   // retire with a dest
	input  rename_pkg::preg_t  release_preg_i, // told of the retiring entry

	output rename_pkg::preg_t  head_preg_o,
	output logic               empty_o
);
	import rename_pkg::*;

	// upper half of the phys regs starts out free
	localparam int FL_SLOTS = NUM_PREG / 2;
	localparam int PTR_W    = $clog2(FL_SLOTS);

	preg_t            slot_q [FL_SLOTS];
	logic [PTR_W-1:0] head_q, tail_q;
	logic [PTR_W:0]   count_q;  // 0 .. FL_SLOTS
	logic             full;

	assign head_preg_o = slot_q[head_q];
	assign empty_o     = (count_q == '0);  // count before the edge
	assign full        = (count_q == (PTR_W+1)'(FL_SLOTS));

	//==============================
	// queue state
	//==============================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < FL_SLOTS; i++) begin
				slot_q[i] <= preg_t'(FL_SLOTS + i); // 32 .. 63 ascending
			end
			head_q  <= '0;
			tail_q  <= '0;  // wraps back onto head when full
			count_q <= (PTR_W+1)'(FL_SLOTS);
		end else begin
			if (release_en_i) begin
				slot_q[tail_q] <= release_preg_i;
				tail_q         <= tail_q + PTR_W'(1);
			end
			if (alloc_en_i) begin
				head_q <= head_q + PTR_W'(1);
			end
			count_q <= count_q + (PTR_W+1)'(release_en_i) - (PTR_W+1)'(alloc_en_i);
		end
	end

	// dispatch must respect empty, rob must never over-release
	a_no_alloc_empty: assert property (@(posedge clk) disable iff (reset_i)
		alloc_en_i |-> !empty_o)
		else $error("free list allocate while empty");
	a_no_release_full: assert property (@(posedge clk) disable iff (reset_i)
		release_en_i |-> !full)
		else $error("free list release while full");

endmodule : free_list

`default_nettype wire

/* reorder_buffer.sv */
/*
 * reorder buffer
 * program-order queue of renamed instructions, done bits set by
 * index on completion, head retires once done and frees told
 */
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
	parameter int ROB_DEPTH = 16  // power of two, 2 .. 32
) (
	input  logic                          clk,
	input  logic                          reset_i,

	// dispatch side
	input  logic                          push_i,
	input  rename_pkg::areg_t             dest_areg_i,
	input  rename_pkg::preg_t             new_preg_i,  // tnew
	input  rename_pkg::preg_t             old_preg_i,  // told
	output logic [$clog2(ROB_DEPTH)-1:0]  tail_idx_o,
	output logic                          full_o,

	// completion, any order
	input  logic                          complete_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]  complete_idx_i,

	// retire, in order
	output logic                          retire_o,
	output logic [$clog2(ROB_DEPTH)-1:0]  retire_idx_o,
	output rename_pkg::areg_t             retire_areg_o,
	output rename_pkg::preg_t             retire_preg_o,
	output logic                          release_en_o,
	output rename_pkg::preg_t             release_preg_o
);
	import rename_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);

	// payload per entry
	areg_t dest_q [ROB_DEPTH];
	preg_t new_q  [ROB_DEPTH];
	preg_t old_q  [ROB_DEPTH];

	// entry status
	logic [ROB_DEPTH-1:0] valid_q;
	logic [ROB_DEPTH-1:0] done_q;
	logic [IDX_W-1:0]     head_q, tail_q;
	logic [IDX_W:0]       count_q;

	assign tail_idx_o = tail_q;
	assign full_o     = (count_q == (IDX_W+1)'(ROB_DEPTH)); // count before the edge

	//==============================
	// head retire
	//==============================
	assign retire_o       = valid_q[head_q] & done_q[head_q];
	assign retire_idx_o   = head_q;
	assign retire_areg_o  = dest_q[head_q];
	assign retire_preg_o  = new_q[head_q];
	assign release_en_o   = retire_o & (dest_q[head_q] != ZERO_REG);
	assign release_preg_o = old_q[head_q];

	// payload written on push only
	always_ff @(posedge clk) begin
		if (push_i) begin
			dest_q[tail_q] <= dest_areg_i;
			new_q[tail_q]  <= new_preg_i;
			old_q[tail_q]  <= old_preg_i;
		end
	end

	//==============================
	// queue control
	//==============================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= '0;
			done_q  <= '0;
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (complete_i) begin
				done_q[complete_idx_i] <= 1'b1;
			end
			if (retire_o) begin
				valid_q[head_q] <= 1'b0;
				head_q          <= head_q + IDX_W'(1); // power of two wrap
			end
			if (push_i) begin  // tail is never the retiring head
				valid_q[tail_q] <= 1'b1;
				done_q[tail_q]  <= 1'b0;
				tail_q          <= tail_q + IDX_W'(1);
			end
			count_q <= count_q + (IDX_W+1)'(push_i) - (IDX_W+1)'(retire_o);
		end
	end

	// outside completion must name a live entry exactly once
	a_complete_live: assert property (@(posedge clk) disable iff (reset_i)
		complete_i |-> (valid_q[complete_idx_i] && !done_q[complete_idx_i]))
		else $error("completion of idle or already done rob entry");
	a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
		push_i |-> !full_o)
		else $error("rob push while full");

endmodule : reorder_buffer

`default_nettype wire

/* rename_core.sv */
/*
 * rename core top
 * dispatch stage, map table, free list and reorder buffer
 */
`timescale 1ns/1ns
`default_nettype none

module rename_core #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                          clk,
	input  logic                          reset_i,

	input  logic                          inst_valid_i,
	input  logic [31:0]                   inst_i,
	input  logic                          complete_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]  complete_idx_i,

	output logic                          stall_o,
	output rename_pkg::preg_t             src_a_preg_o,
	output rename_pkg::preg_t             src_b_preg_o,
	output rename_pkg::preg_t             dest_preg_o,
	output logic [$clog2(ROB_DEPTH)-1:0]  rob_idx_o,
	output logic                          retire_o,
	output logic [$clog2(ROB_DEPTH)-1:0]  retire_rob_idx_o,
	output rename_pkg::areg_t             retire_areg_o,
	output rename_pkg::preg_t             retire_preg_o
);
	import rename_pkg::*;

	logic  dispatch_en, alloc_en;
	logic  rob_full, fl_empty;
	logic  release_en;
	areg_t src_a_areg, src_b_areg, dest_areg;
	preg_t fl_head_preg, old_preg, new_preg, release_preg;

	// no dest means dest_areg is r31, whose mapping reads 31
	assign new_preg    = alloc_en ? fl_head_preg : old_preg;
	assign dest_preg_o = new_preg;

	//==============================
	// dispatch
	//==============================
	dispatch_stage dispatch_stage (
		.inst_valid_i  (inst_valid_i),
		.inst_i        (inst_i),
		.rob_full_i    (rob_full),
		.fl_empty_i    (fl_empty),
		.stall_o       (stall_o),
		.dispatch_en_o (dispatch_en),
		.alloc_en_o    (alloc_en),
		.src_a_areg_o  (src_a_areg),
		.src_b_areg_o  (src_b_areg),
		.dest_areg_o   (dest_areg)
	);

	//==============================
	// rename state
	//==============================
	map_table map_table (
		.clk           (clk),
		.reset_i       (reset_i),
		.dispatch_en_i (dispatch_en),
		.src_a_areg_i  (src_a_areg),
		.src_b_areg_i  (src_b_areg),
		.dest_areg_i   (dest_areg),
		.new_preg_i    (new_preg),
		.src_a_preg_o  (src_a_preg_o),
		.src_b_preg_o  (src_b_preg_o),
		.old_preg_o    (old_preg)
	);

	free_list free_list (
		.clk            (clk),
		.reset_i        (reset_i),
		.alloc_en_i     (alloc_en),
		.release_en_i   (release_en),   // from rob retire
		.release_preg_i (release_preg),
		.head_preg_o    (fl_head_preg),
		.empty_o        (fl_empty)
	);

	//==============================
	// retire
	//==============================
	reorder_buffer #(
		.ROB_DEPTH (ROB_DEPTH)
	) reorder_buffer (
		.clk            (clk),
		.reset_i        (reset_i),
		.push_i         (dispatch_en),
		.dest_areg_i    (dest_areg),
		.new_preg_i     (new_preg),
		.old_preg_i     (old_preg),
		.tail_idx_o     (rob_idx_o),
		.full_o         (rob_full),
		.complete_i     (complete_i),
		.complete_idx_i (complete_idx_i),
		.retire_o       (retire_o),
		.retire_idx_o   (retire_rob_idx_o),
		.retire_areg_o  (retire_areg_o),
		.retire_preg_o  (retire_preg_o),
		.release_en_o   (release_en),
		.release_preg_o (release_preg)
	);

endmodule : rename_core

`default_nettype wire

/* tb_clock.sv */
/*
 * testbench clock and reset
 * free running clock, synchronous reset held for a few edges
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 10,  // ns
	parameter int RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic reset_o
);
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 reset_o = 1'b0; // drops with the other inputs
	end

endmodule : tb_clock

`default_nettype wire

/* rename_tb.sv */
/*
 * rename core testbench
 * random instruction stream against a reference rename model,
 * out of order completion, in order retire and free list reuse
 */
`timescale 1ns/1ns
`default_nettype none

module rename_tb;
	import rename_pkg::*;

	localparam int ROB_DEPTH  = 16;
	localparam int IDX_W      = $clog2(ROB_DEPTH);
	localparam int ENT_W      = IDX_W + AREG_W + 2 * PREG_W; // {idx, dest, new, old}
	localparam int REN_W      = 3 * PREG_W + IDX_W;          // {src a, src b, dest, idx}
	localparam int N_INST     = 240;  // enough to recycle the free list
	localparam int MAX_CYCLES = 20 * (N_INST + ROB_DEPTH);
	localparam int HOLD_STALL = 4;    // full rob stall cycles before the first completion

	logic             clk, reset;
	logic             inst_valid, complete, stall, retire;
	logic [31:0]      inst;
	logic [IDX_W-1:0] complete_idx, rob_idx, retire_idx;
	preg_t            src_a_preg, src_b_preg, dest_preg, retire_preg;
	areg_t            retire_areg;

	//==============================
	// reference model state
	//==============================
	preg_t                map_m [32];
	preg_t                free_m [$];
	logic [ENT_W-1:0]     rob_m [$];     // program order
	logic [IDX_W-1:0]     pending [$];   // dispatched, not yet completed
	logic [ROB_DEPTH-1:0] done_m;
	logic [IDX_W-1:0]     tail_m;
	int                   n_accepted, n_alloc, stall_cycles;

	logic [15:0] lfsr;
	int          issued, pick;
	logic        head_completed;
	int          cycle_count = 0;

	tb_clock #(.PERIOD(10), .RESET_CYCLES(2)) clock_gen (.clk_o(clk), .reset_o(reset));

	rename_core #(.ROB_DEPTH(ROB_DEPTH)) uut (
		.clk (clk), .reset_i (reset),
		.inst_valid_i (inst_valid), .inst_i (inst),
		.complete_i (complete), .complete_idx_i (complete_idx),
		.stall_o (stall), .src_a_preg_o (src_a_preg), .src_b_preg_o (src_b_preg),
		.dest_preg_o (dest_preg), .rob_idx_o (rob_idx), .retire_o (retire),
		.retire_rob_idx_o (retire_idx), .retire_areg_o (retire_areg),
		.retire_preg_o (retire_preg)
	);

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s: got %0d, expected %0d", $time, what, actual,
				expected);
			$display("Testbench failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// galois lfsr with taps x^16+x^14+x^13+x^11+1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 16'hb400;
		return b;
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [31:0] make_inst();
		logic [2:0] cls;
		logic [5:0] opc;
		logic [4:0] ra, rb, rc;
		cls = 3'(draw_bits(3));
		ra  = 5'(draw_bits(5));
		rb  = 5'(draw_bits(5));
		rc  = 5'(draw_bits(5));
		case (cls)
			3'd4:    opc = OP_LDQ;
			3'd5:    opc = OP_STQ;
			3'd6:    opc = {2'b11, 4'(draw_bits(4))}; // branch 0x30..0x3f
			3'd7:    opc = {2'b00, 4'(draw_bits(4))}; // unknown 0x00..0x0f
			default: opc = OP_INTA + {4'b0000, cls[1:0]}; // half the stream operates
		endcase
		return {opc, ra, rb, 11'h000, rc};
	endfunction

	// decode table giving {src a, src b, dest}
	function automatic logic [3*AREG_W-1:0] decode_regs(input logic [31:0] w);
		logic [5:0] opc;
		areg_t      ra, rb, rc;
		opc = w[31:26];
		ra  = w[25:21];
		rb  = w[20:16];
		rc  = w[4:0];
		if (opc >= OP_INTA && opc <= OP_INTM) return {ra, rb, rc};
		if (opc == OP_LDQ) return {ZERO_REG, rb, ra};
		if (opc == OP_STQ) return {ra, rb, ZERO_REG};
		if (opc >= OP_BR_LO) return {ra, ZERO_REG, ZERO_REG};
		return {ZERO_REG, ZERO_REG, ZERO_REG};
	endfunction

	// accepted dispatch gives {src a, src b, dest, rob idx}
	function automatic logic [REN_W-1:0] rename_model(input logic [31:0] w);
		areg_t            sa, sb, d;
		preg_t            pa, pb, pn, po;
		logic [IDX_W-1:0] idx;
		{sa, sb, d} = decode_regs(w);
		pa = map_m[sa];  // mapping before own update
		pb = map_m[sb];
		po = map_m[d];
		pn = preg_t'(31);
		if (d != ZERO_REG) begin
			pn = free_m.pop_front();
			map_m[d] = pn;
			n_alloc++;
		end
		idx = tail_m;
		tail_m = tail_m + IDX_W'(1);
		done_m[idx] = 1'b0;
		rob_m.push_back({idx, d, pn, po});
		return {pa, pb, pn, idx};
	endfunction

	// oldest entry retires and gives {idx, dest, new preg}
	function automatic logic [IDX_W+AREG_W+PREG_W-1:0] retire_model();
		logic [ENT_W-1:0] e;
		e = rob_m.pop_front();
		if (e[2*PREG_W +: AREG_W] != ZERO_REG) free_m.push_back(e[PREG_W-1:0]); // told
		return e[ENT_W-1:PREG_W];
	endfunction

	//==============================
	// compare at mid cycle
	//==============================
	always @(negedge clk) begin : compare
		logic [3*AREG_W-1:0]            regs;
		logic [REN_W-1:0]               ren;
		logic [IDX_W+AREG_W+PREG_W-1:0] ret;
		logic [ENT_W-1:0]               head;
		logic                           exp_retire, exp_stall;
		int                             pos;
		if (reset !== 1'b0) begin
			for (int i = 0; i < 32; i++) map_m[i] = preg_t'(i); // identity
			free_m.delete();
			for (int i = 32; i < NUM_PREG; i++) free_m.push_back(preg_t'(i));
			rob_m.delete();
			pending.delete();
			done_m = '0;
			tail_m = '0;
			n_accepted = 0;
			n_alloc = 0;
			stall_cycles = 0;
		end else begin
			exp_retire = 1'b0;
			if (rob_m.size() > 0) begin
				head = rob_m[0];
				exp_retire = done_m[head[ENT_W-1 -: IDX_W]];
			end
			check_eq(32'(retire), 32'(exp_retire), "retire strobe");
			if (inst_valid) begin
				regs = decode_regs(inst);
				// counts before the edge
				exp_stall = (rob_m.size() == ROB_DEPTH) ||
					((regs[AREG_W-1:0] != ZERO_REG) && (free_m.size() == 0));
				check_eq(32'(stall), 32'(exp_stall), "dispatch stall");
				if (exp_stall) begin
					stall_cycles++;
				end else begin
					ren = rename_model(inst);
					check_eq(32'(src_a_preg), 32'(ren[IDX_W+2*PREG_W +: PREG_W]), "src a preg");
					check_eq(32'(src_b_preg), 32'(ren[IDX_W+PREG_W +: PREG_W]), "src b preg");
					check_eq(32'(dest_preg), 32'(ren[IDX_W +: PREG_W]), "dest preg");
					check_eq(32'(rob_idx), 32'(ren[IDX_W-1:0]), "rob index");
					pending.push_back(ren[IDX_W-1:0]);
					n_accepted++;
				end
			end
			if (exp_retire) begin
				ret = retire_model();
				check_eq(32'(retire_idx), 32'(ret[PREG_W+AREG_W +: IDX_W]), "retire index");
				check_eq(32'(retire_areg), 32'(ret[PREG_W +: AREG_W]), "retire dest areg");
				check_eq(32'(retire_preg), 32'(ret[PREG_W-1:0]), "retire new preg");
			end
			if (complete) begin
				done_m[complete_idx] = 1'b1;
				pos = -1;
				for (int i = 0; i < pending.size(); i++) begin
					if (pending[i] == complete_idx) pos = i;
				end
				if (pos >= 0) pending.delete(pos);
			end
		end
	end

	//==============================
	// stimulus 1 ns after the edge
	//==============================
	initial begin
		inst_valid = 1'b0;
		inst = '0;
		complete = 1'b0;
		complete_idx = '0;
		lfsr = 16'd49065;
		issued = 0;
		pick = 0;
		head_completed = 1'b0;
		@(negedge reset);
		while (!(issued == N_INST && n_accepted == N_INST && rob_m.size() == 0)) begin
			@(posedge clk);
			#1;
			complete = 1'b0;
			if (n_accepted == issued) begin // last one taken
				if (issued < N_INST) begin
					inst = make_inst();
					inst_valid = 1'b1;
					issued++;
				end else begin
					inst_valid = 1'b0;
				end
			end
			if (n_accepted < ROB_DEPTH + 1) begin
				// fill the rob and hold the 17th until the head is freed once
				if (stall_cycles >= HOLD_STALL && !head_completed && pending.size() > 0) begin
					complete = 1'b1;
					complete_idx = pending[0];
					head_completed = 1'b1;
				end
			end else if (pending.size() > 0 && draw_bits(2) != 0) begin
				pick = int'(draw_bits(4)) % pending.size(); // any in-flight entry
				complete = 1'b1;
				complete_idx = pending[pick];
			end
		end
		repeat (2) @(posedge clk);
		check_eq(32'(n_alloc > 32), 32'd1, "released pregs reused");
		$display("Testbench passed");
		$finish;
	end

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$fatal(1, "timeout");
		end
	end

endmodule : rename_tb

`default_nettype wire

/* src.f */
rename_pkg.sv
dispatch_stage.sv
map_table.sv
free_list.sv
reorder_buffer.sv
rename_core.sv
tb_clock.sv
rename_tb.sv

/* Makefile */
# rename core simulation with Verilator

VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAIL"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
